/* hdl/cam_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "line_swap_defs.svh"

module cam_decode #(
    parameter int depth = `LS_FIFO_DEPTH,
    parameter int h_act = `LS_H_ACT
) (
    input  logic                             rclk,
    input  logic                             rstn,
    input  logic [line_swap_pkg::pack_w-1:0] pack,
    cam_line_if.decode                       cam
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);
    localparam logic [cnt_w-1:0] full_cnt = cnt_w'(depth);
    localparam logic [cnt_w-1:0] line_cnt = cnt_w'(h_act);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);

    logic [15:0]      mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic [15:0]      pixel;
    logic             de;
    logic             full;
    logic             empty;
    logic             do_wr;
    logic             do_rd;

    assign de = pack[line_swap_pkg::de_bit];

    // rgb888 to rgb565 keeps the top bits of each channel.
    assign pixel = {pack[line_swap_pkg::red_hi -: 5],
                    pack[line_swap_pkg::green_hi -: 6],
                    pack[line_swap_pkg::blue_hi -: 5]};

    assign full  = count == full_cnt;
    assign empty = count == '0;
    assign do_wr = de && !full;
    assign do_rd = cam.rd_en && !empty;

    assign cam.vsync      = pack[line_swap_pkg::vsync_bit];
    assign cam.line_ready = count >= line_cnt;

    always_ff @(posedge rclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= pixel;
        end
        if (do_rd) begin
            cam.rd_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            cam.overflow <= 1'b0;
        end else begin
            // a pixel that finds the buffer full is dropped.
            cam.overflow <= de && full;
            if (do_wr) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    count_in_range: assert property (@(posedge rclk) disable iff (!rstn)
        count <= full_cnt)
        else $error("cam_decode: fill count above depth");

endmodule

`default_nettype wire

/* hdl/cam_line_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface cam_line_if;

    logic        vsync;
    logic        overflow;
    logic        line_ready;
    logic [15:0] rd_data;
    logic        rd_en;

    modport decode (
        output vsync,
        output overflow,
        output line_ready,
        output rd_data,
        input  rd_en
    );

    // overflow goes to the error stage at the top, not to the interleaver.
    modport execute (
        input  vsync,
        input  line_ready,
        input  rd_data,
        output rd_en
    );

endinterface

`default_nettype wire

/* hdl/error_hold.sv */
`timescale 1ns/1ps
`default_nettype none

`include "line_swap_defs.svh"

module error_hold #(
    parameter int hold_cycles = `LS_ERR_HOLD
) (
    input  logic rclk,
    input  logic rstn,
    input  logic fault,
    output logic error
);

    localparam int cnt_w = $clog2(hold_cycles + 1);
    localparam logic [cnt_w-1:0] reload = cnt_w'(hold_cycles);

    logic [cnt_w-1:0] count;

    // every new fault restarts the hold window.
    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            count <= '0;
        end else if (fault) begin
            count <= reload;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign error = count != '0;

endmodule

`default_nettype wire

/* hdl/line_interleave.sv */
`timescale 1ns/1ps
`default_nettype none

`include "line_swap_defs.svh"

module line_interleave #(
    parameter int h_act = `LS_H_ACT,
    parameter int v_act = `LS_V_ACT
) (
    input  logic        rclk,
    input  logic        rstn,
    input  logic        trig,
    input  logic        read_en,
    cam_line_if.execute cam1,
    cam_line_if.execute cam2,
    output logic        cam_id,
    output logic        valid,
    output logic [15:0] cam_data,
    output logic [9:0]  cam_row,
    output logic        vsync_err
);

    localparam int px_w = $clog2(h_act + 1);
    localparam logic [px_w-1:0] px_last  = px_w'(h_act - 1);
    localparam logic [px_w-1:0] px_all   = px_w'(h_act);
    localparam logic [9:0]      row_last = 10'(v_act - 1);

    line_swap_pkg::ilv_state_e state;

    logic [px_w-1:0] rd_cnt;
    logic [px_w-1:0] px_cnt;
    logic [9:0]      row;
    logic            vs1_d;
    logic            vs2_d;
    logic            fall1;
    logic            fall2;
    logic            in_read;
    logic            issue;
    logic            line_done;

    assign fall1     = vs1_d && !cam1.vsync;
    assign fall2     = vs2_d && !cam2.vsync;
    assign in_read   = state == line_swap_pkg::st_read_cam1 ||
                       state == line_swap_pkg::st_read_cam2;
    assign issue     = in_read && read_en && rd_cnt != px_all;
    assign line_done = valid && px_cnt == px_last;

    // cam_id lags the state by one cycle, so it lines up with the popped word.
    assign cam_data = cam_id ? cam2.rd_data : cam1.rd_data;

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state      <= line_swap_pkg::st_idle;
            rd_cnt     <= '0;
            px_cnt     <= '0;
            row        <= '0;
            vs1_d      <= 1'b0;
            vs2_d      <= 1'b0;
            cam1.rd_en <= 1'b0;
            cam2.rd_en <= 1'b0;
            valid      <= 1'b0;
            cam_id     <= 1'b0;
            cam_row    <= '0;
            vsync_err  <= 1'b0;
        end else begin
            vs1_d      <= cam1.vsync;
            vs2_d      <= cam2.vsync;
            cam1.rd_en <= issue && state == line_swap_pkg::st_read_cam1;
            cam2.rd_en <= issue && state == line_swap_pkg::st_read_cam2;
            valid      <= cam1.rd_en || cam2.rd_en;
            cam_id     <= state == line_swap_pkg::st_wait_cam2 ||
                          state == line_swap_pkg::st_read_cam2;
            cam_row    <= row;
            vsync_err  <= 1'b0;
            if (issue) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
            if (valid) begin
                px_cnt <= px_cnt + 1'b1;
            end

            case (state)
                line_swap_pkg::st_idle: begin
                    if (trig) begin
                        state <= line_swap_pkg::st_wait_vsync;
                    end
                end
                line_swap_pkg::st_wait_vsync: begin
                    // one camera leaving vsync alone means the pair is out of step.
                    if (fall1 != fall2) begin
                        vsync_err <= 1'b1;
                        state     <= line_swap_pkg::st_idle;
                    end else if (cam1.vsync && cam2.vsync) begin
                        row   <= '0;
                        state <= line_swap_pkg::st_wait_cam1;
                    end
                end
                line_swap_pkg::st_wait_cam1: begin
                    rd_cnt <= '0;
                    px_cnt <= '0;
                    if (cam1.line_ready) begin
                        state <= line_swap_pkg::st_read_cam1;
                    end
                end
                line_swap_pkg::st_read_cam1: begin
                    if (line_done) begin
                        state <= line_swap_pkg::st_wait_cam2;
                    end
                end
                line_swap_pkg::st_wait_cam2: begin
                    rd_cnt <= '0;
                    px_cnt <= '0;
                    if (cam2.line_ready) begin
                        state <= line_swap_pkg::st_read_cam2;
                    end
                end
                line_swap_pkg::st_read_cam2: begin
                    if (line_done) begin
                        if (row == row_last) begin
                            state <= line_swap_pkg::st_idle;
                        end else begin
                            row   <= row + 1'b1;
                            state <= line_swap_pkg::st_wait_cam1;
                        end
                    end
                end
                default: begin
                    state <= line_swap_pkg::st_idle;
                end
            endcase
        end
    end

    one_reader: assert property (@(posedge rclk) disable iff (!rstn)
        !(cam1.rd_en && cam2.rd_en))
        else $error("line_interleave: both line buffers read at once");

    no_valid_idle: assert property (@(posedge rclk) disable iff (!rstn)
        state == line_swap_pkg::st_idle |-> !valid)
        else $error("line_interleave: valid while idle");

endmodule

`default_nettype wire

/* hdl/line_swap_pkg.sv */
`default_nettype none

package line_swap_pkg;

    typedef enum logic [2:0] {
        st_idle,
        st_wait_vsync,
        st_wait_cam1,
        st_read_cam1,
        st_wait_cam2,
        st_read_cam2
    } ilv_state_e;

    // layout of the 49-bit camera pack.
    localparam int pack_w    = 49;
    localparam int blue_lo   = 0;
    localparam int blue_hi   = 7;
    localparam int green_lo  = 8;
    localparam int green_hi  = 15;
    localparam int red_lo    = 16;
    localparam int red_hi    = 23;
    localparam int de_bit    = 24;
    localparam int hsync_bit = 25;
    localparam int vsync_bit = 26;
    // the camera clock is sampled in rclk and not used by the design.
    localparam int clk_bit   = 48;

endpackage

`default_nettype wire

/* hdl/line_swap_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "line_swap_defs.svh"

module line_swap_top #(
    parameter int h_act = `LS_H_ACT,
    parameter int v_act = `LS_V_ACT
) (
    input  logic        rclk,
    input  logic        rstn,
    input  logic        trig,
    input  logic        read_en,
    input  logic [48:0] cam1_pack,
    input  logic [48:0] cam2_pack,
    output logic        cam_id,
    output logic        valid,
    output logic [15:0] cam_data,
    output logic [9:0]  cam_row,
    output logic        error
);

    logic vsync_err;
    logic cam1_error;
    logic cam2_error;
    logic vsync_error;

    cam_line_if cam1_if ();
    cam_line_if cam2_if ();

    cam_decode #(.depth(`LS_FIFO_DEPTH), .h_act(h_act)) u_cam1_decode (
        .rclk (rclk),
        .rstn (rstn),
        .pack (cam1_pack),
        .cam  (cam1_if)
    );

    cam_decode #(.depth(`LS_FIFO_DEPTH), .h_act(h_act)) u_cam2_decode (
        .rclk (rclk),
        .rstn (rstn),
        .pack (cam2_pack),
        .cam  (cam2_if)
    );

    line_interleave #(.h_act(h_act), .v_act(v_act)) u_interleave (
        .rclk      (rclk),
        .rstn      (rstn),
        .trig      (trig),
        .read_en   (read_en),
        .cam1      (cam1_if),
        .cam2      (cam2_if),
        .cam_id    (cam_id),
        .valid     (valid),
        .cam_data  (cam_data),
        .cam_row   (cam_row),
        .vsync_err (vsync_err)
    );

    error_hold #(.hold_cycles(`LS_ERR_HOLD)) u_cam1_err (
        .rclk  (rclk),
        .rstn  (rstn),
        .fault (cam1_if.overflow),
        .error (cam1_error)
    );

    error_hold #(.hold_cycles(`LS_ERR_HOLD)) u_cam2_err (
        .rclk  (rclk),
        .rstn  (rstn),
        .fault (cam2_if.overflow),
        .error (cam2_error)
    );

    error_hold #(.hold_cycles(`LS_ERR_HOLD)) u_vsync_err (
        .rclk  (rclk),
        .rstn  (rstn),
        .fault (vsync_err),
        .error (vsync_error)
    );

    assign error = cam1_error || cam2_error || vsync_error;

endmodule

`default_nettype wire

/* include/line_swap_defs.svh */
`ifndef LINE_SWAP_DEFS_SVH
`define LINE_SWAP_DEFS_SVH

// active pixels in one line of each camera.
`define LS_H_ACT 8

// active rows in one frame.
`define LS_V_ACT 4

// one line buffer per camera; must hold at least one full line.
`define LS_FIFO_DEPTH 16

// cycles an error level stays up after the last fault.
`define LS_ERR_HOLD 32

`endif

/* line_swap_top.f */
+incdir+include
hdl/line_swap_pkg.sv
hdl/cam_line_if.sv
hdl/cam_decode.sv
hdl/line_interleave.sv
hdl/error_hold.sv
hdl/line_swap_top.sv
testbench/tb_line_swap.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_line_swap \
        -f line_swap_top.f -o tb_line_swap \
    && ./obj_dir/tb_line_swap \
    || exit 1

/* testbench/tb_line_swap.sv */
`timescale 1ns/1ps
`default_nettype none

`include "line_swap_defs.svh"

module tb_line_swap;

    localparam int h_act = `LS_H_ACT;
    localparam int v_act = `LS_V_ACT;
    // the directed tests run for well under 1500 cycles.
    localparam int max_cycles = 4000;

    logic        rclk = 1'b0;
    logic        rstn;
    logic        trig;
    logic        read_en;
    logic [48:0] cam1_pack;
    logic [48:0] cam2_pack;
    logic        cam_id;
    logic        valid;
    logic [15:0] cam_data;
    logic [9:0]  cam_row;
    logic        error;

    // each entry is {cam_id, cam_row, cam_data} in output order.
    logic [26:0] exp_q [$];
    int          seed;
    int          cycles;
    int          lines_done;
    int          px_seen;
    logic        bp_on;

    line_swap_top i_dut (
        .rclk      (rclk),
        .rstn      (rstn),
        .trig      (trig),
        .read_en   (read_en),
        .cam1_pack (cam1_pack),
        .cam2_pack (cam2_pack),
        .cam_id    (cam_id),
        .valid     (valid),
        .cam_data  (cam_data),
        .cam_row   (cam_row),
        .error     (error)
    );

    initial begin
        forever #50 rclk = ~rclk;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic compare(input string name, input int expected, input int actual);
        assert (expected == actual)
        else stop_with_failure($sformatf("[ERROR] %0t ns: %s expected 0x%0h, got 0x%0h",
                                         $time, name, expected, actual));
    endtask

    // rgb888 to rgb565 keeps the top five, six and five bits.
    function automatic logic [15:0] to_rgb565(input logic [23:0] rgb);
        return {rgb[23:19], rgb[15:10], rgb[7:3]};
    endfunction

    function automatic logic [48:0] pack_pixel(input logic vs, input logic de,
                                               input logic [23:0] rgb);
        logic [48:0] p;
        p = '0;
        p[line_swap_pkg::vsync_bit] = vs;
        p[line_swap_pkg::de_bit] = de;
        p[line_swap_pkg::red_hi:line_swap_pkg::red_lo] = rgb[23:16];
        p[line_swap_pkg::green_hi:line_swap_pkg::green_lo] = rgb[15:8];
        p[line_swap_pkg::blue_hi:line_swap_pkg::blue_lo] = rgb[7:0];
        return p;
    endfunction

    task automatic check_output_pixel();
        logic [26:0] e;
        assert (exp_q.size() != 0)
        else stop_with_failure("valid was high with no pixel expected by the model");
        e = exp_q.pop_front();
        compare("cam_id", int'(e[26]), int'(cam_id));
        compare("cam_row", int'(e[25:16]), int'(cam_row));
        compare("cam_data", int'(e[15:0]), int'(cam_data));
        px_seen++;
        if (px_seen == h_act) begin
            px_seen = 0;
            lines_done++;
        end
    endtask

    // outputs are sampled and inputs driven on the falling edge.
    task automatic next_cycle();
        @(negedge rclk);
        cycles++;
        assert (cycles < max_cycles)
        else stop_with_failure("timeout: the run went past its cycle limit");
        if (valid) begin
            check_output_pixel();
        end
        if (bp_on) begin
            read_en = 1'($random(seed));
        end
    endtask

    task automatic wait_for_error(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (error !== level && n < limit) begin
            next_cycle();
            n++;
        end
        assert (error === level) else stop_with_failure(what);
    endtask

    task automatic drive_line_pair(input int row);
        logic [23:0] rgb1 [h_act];
        logic [23:0] rgb2 [h_act];
        int p;
        for (p = 0; p < h_act; p++) begin
            rgb1[p] = 24'($random(seed));
            rgb2[p] = 24'($random(seed));
            exp_q.push_back({1'b0, 10'(row), to_rgb565(rgb1[p])});
        end
        for (p = 0; p < h_act; p++) begin
            exp_q.push_back({1'b1, 10'(row), to_rgb565(rgb2[p])});
        end
        for (p = 0; p < h_act; p++) begin
            cam1_pack = pack_pixel(1'b0, 1'b1, rgb1[p]);
            cam2_pack = pack_pixel(1'b0, 1'b1, rgb2[p]);
            next_cycle();
        end
        cam1_pack = '0;
        cam2_pack = '0;
        next_cycle();
    endtask

    task automatic drive_frame(input logic bp);
        int r;
        lines_done = 0;
        px_seen = 0;
        bp_on = bp;
        read_en = 1'b1;
        trig = 1'b1;
        next_cycle();
        trig = 1'b0;
        cam1_pack = pack_pixel(1'b1, 1'b0, 24'h0);
        cam2_pack = pack_pixel(1'b1, 1'b0, 24'h0);
        repeat (2) next_cycle();
        cam1_pack = '0;
        cam2_pack = '0;
        next_cycle();
        for (r = 0; r < v_act; r++) begin
            // a new row goes in once the previous one has left both buffers.
            while (lines_done < 2 * r) begin
                next_cycle();
            end
            drive_line_pair(r);
        end
        while (lines_done < 2 * v_act) begin
            next_cycle();
        end
        bp_on = 1'b0;
        read_en = 1'b1;
        repeat (20) next_cycle();
        assert (exp_q.size() == 0)
        else stop_with_failure("the frame ended with expected pixels never output");
        compare("error", 0, int'(error));
    endtask

    task automatic idle_after_reset();
        int n;
        // a lone vsync fall before any trig must leave the interleaver idle.
        for (n = 0; n < 10; n++) begin
            cam1_pack = pack_pixel(n >= 2 && n < 5, 1'b0, 24'h0);
            next_cycle();
            compare("valid", 0, int'(valid));
            compare("cam_id", 0, int'(cam_id));
            compare("error", 0, int'(error));
        end
    endtask

    task automatic vsync_misalignment();
        read_en = 1'b1;
        cam1_pack = pack_pixel(1'b1, 1'b0, 24'h0);
        next_cycle();
        trig = 1'b1;
        next_cycle();
        trig = 1'b0;
        // Camera 1 leaves vsync while camera 2 never entered it.
        cam1_pack = '0;
        wait_for_error(1'b1, 4, "error did not rise after the vsync misalignment");
        wait_for_error(1'b0, `LS_ERR_HOLD + 2, "error stayed high past its hold time");
        drive_frame(1'b0);
    endtask

    task automatic line_overflow();
        int p;
        read_en = 1'b0;
        for (p = 0; p < `LS_FIFO_DEPTH + 4; p++) begin
            cam2_pack = pack_pixel(1'b0, 1'b1, 24'($random(seed)));
            next_cycle();
        end
        cam2_pack = '0;
        wait_for_error(1'b1, 4, "error did not rise after the line buffer overflow");
        wait_for_error(1'b0, `LS_ERR_HOLD + 2, "error stayed high past its hold time");
    endtask

    initial begin
        seed = 70;
        cycles = 0;
        lines_done = 0;
        px_seen = 0;
        bp_on = 1'b0;
        rstn = 1'b0;
        trig = 1'b0;
        read_en = 1'b0;
        cam1_pack = '0;
        cam2_pack = '0;
        repeat (8) next_cycle();
        rstn = 1'b1;
        idle_after_reset();
        drive_frame(1'b0);
        drive_frame(1'b1);
        vsync_misalignment();
        line_overflow();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
